// ==== logic/mem_dispatch_pkg.sv ====
// data widths, access size and kind encodings, and the beat limit of the memory dispatcher
package mem_dispatch_pkg;

    typedef logic [31:0] addr_t;      // byte address
    typedef logic [31:0] word_t;      // instruction, load result or store data
    typedef logic [7:0]  mem_byte_t;  // one byte on the memory port
    typedef logic [2:0]  beat_t;      // beat index within an access

    // encoding used on the load and store size ports
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } access_size_t;

    // FSM state and read beat tag
    typedef enum logic [1:0] {
        kind_idle  = 2'd0,
        kind_fetch = 2'd1,
        kind_load  = 2'd2,
        kind_store = 2'd3
    } access_kind_t;

    localparam beat_t MAX_BEATS = 3'd4;  // beats of a word access

endpackage

// ==== logic/request_latches.sv ====
// pending fetch, load and store slots with the per-requester free levels
`timescale 1ns/1ns

module request_latches import mem_dispatch_pkg::*; (
    input  logic         in_clk,
    input  logic         in_rst,
    input  logic         flush,
    input  logic         fetch_req,
    input  logic         load_req,
    input  logic         store_req,
    input  addr_t        fetch_addr,
    input  addr_t        load_addr,
    input  addr_t        store_addr,
    input  access_size_t load_size,
    input  access_size_t store_size,
    input  word_t        store_data,
    input  logic         release_fetch,
    input  logic         release_load,
    input  logic         release_store,
    output logic         fetch_pending,
    output logic         load_pending,
    output logic         store_pending,
    output logic         fetch_free,
    output logic         load_free,
    output logic         store_free,
    output addr_t        fetch_addr_q,
    output addr_t        load_addr_q,
    output addr_t        store_addr_q,
    output access_size_t load_size_q,
    output access_size_t store_size_q,
    output word_t        store_data_q
);

    always_ff @(posedge in_clk) begin
        if (in_rst || flush) begin
            fetch_pending <= 1'b0;
            load_pending  <= 1'b0;
            store_pending <= 1'b0;
        end else begin
            if (release_fetch)
                fetch_pending <= 1'b0;
            if (fetch_req)
                fetch_pending <= 1'b1;
            if (release_load)
                load_pending <= 1'b0;
            if (load_req)
                load_pending <= 1'b1;
            if (release_store)
                store_pending <= 1'b0;
            if (store_req)
                store_pending <= 1'b1;
        end
    end

    always_ff @(posedge in_clk) begin
        if (fetch_req)
            fetch_addr_q <= fetch_addr;
        if (load_req) begin
            load_addr_q <= load_addr;
            load_size_q <= load_size;
        end
        if (store_req) begin
            store_addr_q <= store_addr;
            store_size_q <= store_size;
            store_data_q <= store_data;
        end
    end

    // a slot stays taken until its release strobe
    assign fetch_free = !fetch_req && !fetch_pending;
    assign load_free  = !load_req  && !load_pending;
    assign store_free = !store_req && !store_pending;

endmodule

// ==== logic/beat_counter.sv ====
// byte beat index of the current access and its last-beat flag
`timescale 1ns/1ns

module beat_counter import mem_dispatch_pkg::*; (
    input  logic         in_clk,
    input  logic         in_rst,
    input  logic         start,
    input  access_kind_t kind,
    input  access_size_t size,
    output beat_t        beat,
    output logic         last_beat
);

    beat_t cnt_q;
    beat_t num_beats;

    assign beat = start ? 3'd0 : cnt_q;  // first beat is issued in the start cycle

    always_ff @(posedge in_clk) begin
        if (in_rst)
            cnt_q <= 3'd0;
        else
            cnt_q <= beat + 3'd1;
    end

    always_comb begin
        num_beats = MAX_BEATS;  // fetch and word accesses
        if (kind == kind_load || kind == kind_store) begin
            case (size)
                size_byte: num_beats = 3'd1;
                size_half: num_beats = 3'd2;
                default:   num_beats = MAX_BEATS;
            endcase
        end
    end

    assign last_beat = (kind != kind_idle) && (beat == num_beats - 3'd1);

endmodule

// ==== logic/dispatch_fsm.sv ====
// memory port arbiter that grants one requester at a time and chains accesses
`timescale 1ns/1ns

module dispatch_fsm import mem_dispatch_pkg::*; (
    input  logic         in_clk,
    input  logic         in_rst,
    input  logic         flush,
    input  logic         fetch_pending,
    input  logic         load_pending,
    input  logic         store_pending,
    input  logic         last_beat,
    output access_kind_t kind,
    output logic         start,
    output logic         release_fetch,
    output logic         release_load,
    output logic         release_store
);

    access_kind_t state_q;
    access_kind_t grant_idle;
    access_kind_t grant_next;
    logic         first_q;      // next cycle issues beat 0 of a chained access
    logic         finishing;
    logic         fetch_ok;
    logic         load_ok;
    logic         store_ok;
    logic [2:0]   fin_d1;       // {store, load, fetch} finished one cycle ago
    logic [2:0]   fin_d2;

    // order depends on the kind that just finished
    function automatic access_kind_t pick(access_kind_t prev, logic f, logic l, logic s);
        access_kind_t sel;
        sel = kind_idle;
        case (prev)
            kind_fetch: begin
                if (l)
                    sel = kind_load;
                else if (s)
                    sel = kind_store;
            end
            kind_load: begin
                if (s)
                    sel = kind_store;
                else if (f)
                    sel = kind_fetch;
            end
            default: begin
                if (f)
                    sel = kind_fetch;
                else if (l)
                    sel = kind_load;
                else if (s)
                    sel = kind_store;
            end
        endcase
        return sel;
    endfunction

    // finished slots stay pending until their data returns
    assign fetch_ok = fetch_pending && !fin_d1[0] && !fin_d2[0];
    assign load_ok  = load_pending  && !fin_d1[1] && !fin_d2[1];
    assign store_ok = store_pending && !fin_d1[2] && !fin_d2[2];

    assign grant_idle = pick(kind_idle, fetch_ok, load_ok, store_ok);

    always_comb begin
        if (flush)
            kind = kind_idle;  // no beat issued in the flush cycle
        else if (state_q == kind_idle)
            kind = grant_idle;
        else
            kind = state_q;
    end

    assign start      = (kind != kind_idle) && ((state_q == kind_idle) || first_q);
    assign finishing  = (kind != kind_idle) && last_beat;
    assign grant_next = pick(kind,
                             fetch_ok && (kind != kind_fetch),
                             load_ok  && (kind != kind_load),
                             store_ok && (kind != kind_store));

    always_ff @(posedge in_clk) begin
        if (in_rst || flush) begin
            state_q <= kind_idle;
            first_q <= 1'b0;
            fin_d1  <= 3'b000;
            fin_d2  <= 3'b000;
        end else begin
            fin_d1 <= {finishing && (kind == kind_store),
                       finishing && (kind == kind_load),
                       finishing && (kind == kind_fetch)};
            fin_d2 <= fin_d1;
            if (finishing) begin
                state_q <= grant_next;  // back to back, no gap
                first_q <= (grant_next != kind_idle);
            end else begin
                state_q <= kind;
                first_q <= 1'b0;
            end
        end
    end

    // reads free their slot with the done pulse, stores after the write
    assign release_fetch = fin_d2[0];
    assign release_load  = fin_d2[1];
    assign release_store = fin_d1[2];

endmodule

// ==== logic/byte_issuer.sv ====
// memory address, write byte and write strobe per beat, plus the read beat tag
`timescale 1ns/1ns

module byte_issuer import mem_dispatch_pkg::*; (
    input  logic         in_clk,
    input  logic         in_rst,
    input  access_kind_t kind,
    input  beat_t        beat,
    input  logic         last_beat,
    input  addr_t        fetch_addr_q,
    input  addr_t        load_addr_q,
    input  addr_t        store_addr_q,
    input  word_t        store_data_q,
    output addr_t        mem_addr,
    output mem_byte_t    mem_wdata,
    output logic         mem_wr,
    output access_kind_t rd_kind,
    output beat_t        rd_beat,
    output logic         rd_last
);

    addr_t base;
    logic  is_read;

    always_comb begin
        case (kind)
            kind_fetch: base = fetch_addr_q;
            kind_load:  base = load_addr_q;
            default:    base = store_addr_q;
        endcase
    end

    assign is_read = (kind == kind_fetch) || (kind == kind_load);

    always_ff @(posedge in_clk) begin
        if (kind != kind_idle) begin
            mem_addr  <= base + addr_t'(beat);
            mem_wdata <= store_data_q[{beat[1:0], 3'b000} +: 8];  // little-endian byte
            rd_beat   <= beat;
        end
    end

    always_ff @(posedge in_clk) begin
        if (in_rst) begin
            mem_wr  <= 1'b0;
            rd_kind <= kind_idle;
            rd_last <= 1'b0;
        end else begin
            mem_wr  <= (kind == kind_store);
            rd_kind <= is_read ? kind : kind_idle;
            rd_last <= is_read && last_beat;
        end
    end

endmodule

// ==== logic/read_assembler.sv ====
// collects returning read bytes into the fetch and load results with done pulses
`timescale 1ns/1ns

module read_assembler import mem_dispatch_pkg::*; (
    input  logic         in_clk,
    input  logic         in_rst,
    input  logic         flush,
    input  access_kind_t rd_kind,
    input  beat_t        rd_beat,
    input  logic         rd_last,
    input  mem_byte_t    mem_rdata,
    output logic         fetch_valid,
    output logic         load_valid,
    output word_t        fetch_inst,
    output word_t        load_value
);

    access_kind_t tag_kind_q;  // lines up with mem_rdata
    beat_t        tag_beat_q;
    logic         tag_last_q;
    word_t        acc_q;
    word_t        merged;
    word_t        result;

    always_comb begin
        merged = acc_q;
        merged[{tag_beat_q[1:0], 3'b000} +: 8] = mem_rdata;
    end

    // the last beat index gives the access size
    always_comb begin
        case (tag_beat_q)
            3'd0:    result = {24'd0, merged[7:0]};
            3'd1:    result = {16'd0, merged[15:0]};
            default: result = merged;
        endcase
    end

    always_ff @(posedge in_clk) begin
        if (in_rst) begin
            tag_kind_q  <= kind_idle;
            tag_last_q  <= 1'b0;
            fetch_valid <= 1'b0;
            load_valid  <= 1'b0;
        end else begin
            tag_kind_q  <= flush ? kind_idle : rd_kind;  // drop bytes in flight
            tag_last_q  <= rd_last && !flush;
            fetch_valid <= !flush && tag_last_q && (tag_kind_q == kind_fetch);
            load_valid  <= !flush && tag_last_q && (tag_kind_q == kind_load);
        end
    end

    always_ff @(posedge in_clk) begin
        tag_beat_q <= rd_beat;
        if (tag_kind_q != kind_idle)
            acc_q <= merged;
        if (tag_last_q && (tag_kind_q == kind_fetch))
            fetch_inst <= result;
        if (tag_last_q && (tag_kind_q == kind_load))
            load_value <= result;
    end

endmodule

// ==== logic/mem_dispatcher.sv ====
// memory dispatcher top level joining the request slots, arbiter, beat issue and read path
`timescale 1ns/1ns

module mem_dispatcher import mem_dispatch_pkg::*; (
    input  logic         in_clk,
    input  logic         in_rst,
    input  logic         flush,
    input  logic         fetch_req,
    input  addr_t        fetch_addr,
    output logic         fetch_free,
    output logic         fetch_valid,
    output word_t        fetch_inst,
    input  logic         load_req,
    input  addr_t        load_addr,
    input  access_size_t load_size,
    output logic         load_free,
    output logic         load_valid,
    output word_t        load_value,
    input  logic         store_req,
    input  addr_t        store_addr,
    input  access_size_t store_size,
    input  word_t        store_data,
    output logic         store_free,
    input  mem_byte_t    mem_rdata,
    output addr_t        mem_addr,
    output mem_byte_t    mem_wdata,
    output logic         mem_wr
);

    logic         fetch_pending;
    logic         load_pending;
    logic         store_pending;
    logic         release_fetch;
    logic         release_load;
    logic         release_store;
    addr_t        fetch_addr_q;
    addr_t        load_addr_q;
    addr_t        store_addr_q;
    access_size_t load_size_q;
    access_size_t store_size_q;
    access_size_t cur_size;
    word_t        store_data_q;
    access_kind_t kind;
    logic         start;
    beat_t        beat;
    logic         last_beat;
    access_kind_t rd_kind;
    beat_t        rd_beat;
    logic         rd_last;

    assign cur_size = (kind == kind_store) ? store_size_q : load_size_q;  // unused for fetch

    request_latches latches_i (
        .in_clk(in_clk), .in_rst(in_rst), .flush(flush),
        .fetch_req(fetch_req), .load_req(load_req), .store_req(store_req),
        .fetch_addr(fetch_addr), .load_addr(load_addr), .store_addr(store_addr),
        .load_size(load_size), .store_size(store_size), .store_data(store_data),
        .release_fetch(release_fetch), .release_load(release_load),
        .release_store(release_store),
        .fetch_pending(fetch_pending), .load_pending(load_pending),
        .store_pending(store_pending),
        .fetch_free(fetch_free), .load_free(load_free), .store_free(store_free),
        .fetch_addr_q(fetch_addr_q), .load_addr_q(load_addr_q),
        .store_addr_q(store_addr_q),
        .load_size_q(load_size_q), .store_size_q(store_size_q),
        .store_data_q(store_data_q)
    );

    dispatch_fsm fsm_i (
        .in_clk(in_clk), .in_rst(in_rst), .flush(flush),
        .fetch_pending(fetch_pending), .load_pending(load_pending),
        .store_pending(store_pending), .last_beat(last_beat),
        .kind(kind), .start(start),
        .release_fetch(release_fetch), .release_load(release_load),
        .release_store(release_store)
    );

    beat_counter counter_i (
        .in_clk(in_clk), .in_rst(in_rst), .start(start),
        .kind(kind), .size(cur_size),
        .beat(beat), .last_beat(last_beat)
    );

    byte_issuer issuer_i (
        .in_clk(in_clk), .in_rst(in_rst),
        .kind(kind), .beat(beat), .last_beat(last_beat),
        .fetch_addr_q(fetch_addr_q), .load_addr_q(load_addr_q),
        .store_addr_q(store_addr_q), .store_data_q(store_data_q),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wr(mem_wr),
        .rd_kind(rd_kind), .rd_beat(rd_beat), .rd_last(rd_last)
    );

    read_assembler assembler_i (
        .in_clk(in_clk), .in_rst(in_rst), .flush(flush),
        .rd_kind(rd_kind), .rd_beat(rd_beat), .rd_last(rd_last),
        .mem_rdata(mem_rdata),
        .fetch_valid(fetch_valid), .load_valid(load_valid),
        .fetch_inst(fetch_inst), .load_value(load_value)
    );

endmodule

// ==== bench/dispatcher_tests.svh ====
// LFSR source, compare tasks, request helpers and the directed dispatcher tests
logic [31:0] lfsr_state = 32'h04b7fd2d;

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);  // x^32 + x^22 + x^2 + x + 1
endfunction

// one LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_state[0]};
        lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
endfunction

function automatic int byte_count(input access_size_t s);
    case (s)
        size_byte: return 1;
        size_half: return 2;
        default:   return 4;
    endcase
endfunction

function automatic access_size_t size_of_index(input int k);
    if (k % 3 == 0)
        return size_byte;
    else if (k % 3 == 1)
        return size_half;
    return size_word;
endfunction

// n model bytes from a, little-endian, zero-extended
function automatic word_t model_bytes(input addr_t a, input int n);
    word_t w;
    w = '0;
    for (int i = 0; i < n; i++)
        w[8*i +: 8] = mem[a[15:0] + 16'(i)];
    return w;
endfunction

task automatic stop_on_error();
    fail_count++;
    $display("Some tests failed");
    $fatal(1, "stopped at the first error");
endtask

task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
        $display("MISMATCH at %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
        stop_on_error();
    end
endtask

task automatic check_byte(input mem_byte_t got, input mem_byte_t exp, input string what);
    if (got !== exp) begin
        $display("MISMATCH at %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
        stop_on_error();
    end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        stop_on_error();
    end
endtask

task automatic poke_word(input addr_t a, input word_t w);
    for (int i = 0; i < 4; i++) begin
        @(posedge in_clk);
        poke_en   <= 1'b1;
        poke_addr <= a[15:0] + 16'(i);
        poke_data <= w[8*i +: 8];
    end
    @(posedge in_clk);
    poke_en <= 1'b0;
    @(negedge in_clk);  // last byte is in the model by now
endtask

task automatic issue_fetch(input addr_t a);
    @(negedge in_clk);
    while (!fetch_free)
        @(negedge in_clk);
    @(posedge in_clk);
    fetch_req  <= 1'b1;
    fetch_addr <= a;
    @(posedge in_clk);
    fetch_req <= 1'b0;
endtask

task automatic issue_load(input addr_t a, input access_size_t sz);
    @(negedge in_clk);
    while (!load_free)
        @(negedge in_clk);
    @(posedge in_clk);
    load_req  <= 1'b1;
    load_addr <= a;
    load_size <= sz;
    @(posedge in_clk);
    load_req <= 1'b0;
endtask

task automatic issue_store(input addr_t a, input access_size_t sz, input word_t d);
    @(negedge in_clk);
    while (!store_free)
        @(negedge in_clk);
    @(posedge in_clk);
    store_req  <= 1'b1;
    store_addr <= a;
    store_size <= sz;
    store_data <= d;
    @(posedge in_clk);
    store_req <= 1'b0;
endtask

// port must be free again in the done cycle
task automatic wait_read_done(input access_kind_t which, output word_t value);
    int n;
    n = 0;
    @(negedge in_clk);
    while (!((which == kind_fetch) ? fetch_valid : load_valid)) begin
        n++;
        if (n > 40) begin
            $display("read done pulse did not arrive within 40 cycles");
            stop_on_error();
        end
        @(negedge in_clk);
    end
    value = (which == kind_fetch) ? fetch_inst : load_value;
    check_flag((which == kind_fetch) ? fetch_free : load_free, 1'b1, "free with done");
endtask

task automatic wait_store_done();
    int n;
    n = 0;
    @(negedge in_clk);
    while (!store_free) begin
        n++;
        if (n > 40) begin
            $display("store_free did not return within 40 cycles");
            stop_on_error();
        end
        @(negedge in_clk);
    end
endtask

task automatic test_after_reset();
    @(negedge in_clk);
    check_flag(fetch_free, 1'b1, "fetch_free after reset");
    check_flag(load_free, 1'b1, "load_free after reset");
    check_flag(store_free, 1'b1, "store_free after reset");
    check_flag(mem_wr, 1'b0, "mem_wr after reset");
    check_flag(fetch_valid, 1'b0, "fetch_valid after reset");
    check_flag(load_valid, 1'b0, "load_valid after reset");
endtask

task automatic test_fetch();
    addr_t a;
    word_t got;
    for (int i = 0; i < 4; i++) begin
        a = rand_bits(15);
        poke_word(a, rand_bits(32));
        issue_fetch(a);
        wait_read_done(kind_fetch, got);
        check_word(got, model_bytes(a, 4), "fetch_inst");
    end
endtask

task automatic test_loads();
    addr_t        a;
    access_size_t sz;
    word_t        got;
    for (int i = 0; i < 6; i++) begin
        sz = size_of_index(i);
        a  = rand_bits(15);
        poke_word(a, rand_bits(32));
        issue_load(a, sz);
        wait_read_done(kind_load, got);
        check_word(got, model_bytes(a, byte_count(sz)), "load_value");
    end
endtask

task automatic test_stores();
    addr_t        a;
    access_size_t sz;
    word_t        data;
    word_t        exp;
    word_t        got;
    for (int i = 0; i < 3; i++) begin
        sz   = size_of_index(i);
        a    = rand_bits(15);
        data = rand_bits(32);
        poke_word(a, ~data);  // every stored byte really changes
        exp = model_bytes(a, 4);
        for (int b = 0; b < byte_count(sz); b++)
            exp[8*b +: 8] = data[8*b +: 8];
        issue_store(a, sz, data);
        wait_store_done();
        for (int b = 0; b < 4; b++)
            check_byte(mem[a[15:0] + 16'(b)], exp[8*b +: 8], "model byte after store");
        issue_load(a, size_word);
        wait_read_done(kind_load, got);
        check_word(got, exp, "word readback after store");
    end
endtask

task automatic test_contention();
    addr_t fa;
    addr_t la;
    addr_t sa;
    word_t sdata;
    word_t fexp;
    word_t lexp;
    int    n;
    int    fetch_at;
    int    load_at;
    fa    = rand_bits(12);
    la    = 32'h4000 | rand_bits(12);
    sa    = 32'h8000 | rand_bits(12);
    sdata = rand_bits(32);
    poke_word(fa, rand_bits(32));
    poke_word(la, rand_bits(32));
    fexp = model_bytes(fa, 4);
    lexp = model_bytes(la, 4);
    @(posedge in_clk);
    fetch_req  <= 1'b1;
    fetch_addr <= fa;
    load_req   <= 1'b1;
    load_addr  <= la;
    load_size  <= size_word;
    store_req  <= 1'b1;
    store_addr <= sa;
    store_size <= size_word;
    store_data <= sdata;
    @(posedge in_clk);
    fetch_req <= 1'b0;
    load_req  <= 1'b0;
    store_req <= 1'b0;
    n        = 0;
    fetch_at = -1;
    load_at  = -1;
    while (fetch_at < 0 || load_at < 0 || !store_free) begin
        @(negedge in_clk);
        n++;
        if (fetch_valid) begin
            fetch_at = n;
            check_word(fetch_inst, fexp, "fetch_inst under contention");
        end
        if (load_valid) begin
            load_at = n;
            check_word(load_value, lexp, "load_value under contention");
        end
        if (n > 60) begin
            $display("contention: the three accesses did not complete within 60 cycles");
            stop_on_error();
        end
    end
    check_flag(fetch_at < load_at, 1'b1, "fetch done before load");
    for (int b = 0; b < 4; b++)
        check_byte(mem[sa[15:0] + 16'(b)], sdata[8*b +: 8], "stored byte under contention");
endtask

task automatic test_flush();
    addr_t a;
    word_t got;
    a = rand_bits(15);
    poke_word(a, rand_bits(32));
    issue_fetch(a);
    @(posedge in_clk);
    flush <= 1'b1;  // two cycles after the request
    @(posedge in_clk);
    flush <= 1'b0;
    for (int i = 0; i < 8; i++) begin
        @(negedge in_clk);
        check_flag(fetch_valid, 1'b0, "fetch_valid after flush");
    end
    check_flag(fetch_free, 1'b1, "fetch_free after flush");
    a = rand_bits(15);
    poke_word(a, rand_bits(32));
    issue_fetch(a);
    wait_read_done(kind_fetch, got);
    check_word(got, model_bytes(a, 4), "fetch_inst after flush");
endtask

// ==== bench/dispatcher_tb.sv ====
// testbench top with clock, reset, byte memory model, DUT instance, watchdog and test order
`timescale 1ns/1ns

module dispatcher_tb import mem_dispatch_pkg::*; ();

    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 200;
    localparam int RESET_CYCLES    = 10;

    logic         in_clk;
    logic         in_rst;
    logic         flush;
    logic         fetch_req;
    addr_t        fetch_addr;
    logic         fetch_free;
    logic         fetch_valid;
    word_t        fetch_inst;
    logic         load_req;
    addr_t        load_addr;
    access_size_t load_size;
    logic         load_free;
    logic         load_valid;
    word_t        load_value;
    logic         store_req;
    addr_t        store_addr;
    access_size_t store_size;
    word_t        store_data;
    logic         store_free;
    mem_byte_t    mem_rdata = 8'h00;
    addr_t        mem_addr;
    mem_byte_t    mem_wdata;
    logic         mem_wr;

    mem_byte_t    mem [0:65535];  // 64 KiB, low 16 address bits
    logic         poke_en;        // preload port of the model
    logic [15:0]  poke_addr;
    mem_byte_t    poke_data;
    int           fail_count = 0;

    mem_dispatcher dut_i (.*);

    `include "dispatcher_tests.svh"

    function automatic mem_byte_t fill_byte(input logic [15:0] a);
        return a[7:0] ^ {a[12:8], a[15:13]} ^ 8'ha5;
    endfunction

    initial begin
        in_clk = 1'b0;
        forever #2 in_clk = ~in_clk;
    end

    // read data comes one cycle after the address
    always @(posedge in_clk) begin
        mem_rdata <= mem[mem_addr[15:0]];
        if (in_rst) begin
            for (int i = 0; i < 65536; i++)
                mem[i[15:0]] = fill_byte(i[15:0]);
        end else if (mem_wr) begin
            mem[mem_addr[15:0]] = mem_wdata;
        end else if (poke_en) begin
            mem[poke_addr] = poke_data;
        end
    end

    initial begin
        in_rst     = 1'b1;
        flush      = 1'b0;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        load_req   = 1'b0;
        load_addr  = '0;
        load_size  = size_byte;
        store_req  = 1'b0;
        store_addr = '0;
        store_size = size_byte;
        store_data = '0;
        poke_en    = 1'b0;
        poke_addr  = '0;
        poke_data  = '0;
        repeat (RESET_CYCLES) @(posedge in_clk);
        in_rst <= 1'b0;
        test_after_reset();
        test_fetch();
        test_loads();
        test_stores();
        test_contention();
        test_flush();
        if (fail_count == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    initial begin
        repeat (RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST) @(posedge in_clk);
        $display("timeout: the tests did not finish within %0d cycles",
                 NUM_TESTS * CYCLES_PER_TEST);
        stop_on_error();
    end

endmodule

// ==== vlog.f ====
+incdir+bench
logic/mem_dispatch_pkg.sv
logic/request_latches.sv
logic/beat_counter.sv
logic/dispatch_fsm.sv
logic/byte_issuer.sv
logic/read_assembler.sv
logic/mem_dispatcher.sv
bench/dispatcher_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the dispatcher testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns --top-module dispatcher_tb \
    -f vlog.f -o dispatcher_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/dispatcher_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "All tests passed"; then
    exit 0
fi
exit 1
